//--- sources.f
+incdir+rtl
rtl/demodPkg.sv
rtl/busDecoder.sv
rtl/demodRegs.sv
rtl/readCollector.sv
rtl/demodRegsTop.sv
dv/demodRegsTb.sv

//--- Bender.yml
package:
  name: demod_regs

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/demodPkg.sv
      - rtl/busDecoder.sv
      - rtl/demodRegs.sv
      - rtl/readCollector.sv
      - rtl/demodRegsTop.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/demodRegsTb.sv

//--- dv/demodRegsTb.sv
`default_nettype none

`include "demodMap_defs.svh"

module demodRegsTb;

    timeunit 1ns;
    timeprecision 100ps;

    import demodPkg::*;

    localparam int NumChan   = `DEMOD_NUM_CHAN;
    localparam int NumTests  = 5;
    localparam int ClkNs     = 20;
    localparam int RstCycles = 3;

    logic                     clk, rstN, cs, wr, rd, rdValid;
    logic [11:0]              addr;
    logic [3:0]               byteEn;
    logic [31:0]              dataIn, dataOut;
    logic [NumChan-1:0]       demodLock, bitsyncLock, highFreqOffset, auBitsyncLock;
    logic [NumChan-1:0]       enableDespreader;
    logic [NumChan*16-1:0]    posDeviation, negDeviation, falseLockAlpha, falseLockThreshold;
    logic [NumChan*5-1:0]     demodMode, amTC;
    logic [NumChan*2-1:0]     bitsyncMode;
    logic [NumChan*4-1:0]     dac0Select, dac1Select, dac2Select;

    // Register images of CONTROL, DACSELECT, FALSELOCK and AMTC.
    logic [31:0] model [NumChan][4];
    logic        lostModel [NumChan];
    logic [31:0] fieldMask [4] = '{32'h0003_801F, 32'h000F_0F0F, 32'hFFFF_FFFF, 32'h0000_001F};
    logic [7:0]  ctlOfs [4] = '{`DEMOD_CONTROL_OFS, `DEMOD_DACSELECT_OFS,
                                `DEMOD_FALSELOCK_OFS, `DEMOD_AMTC_OFS};
    logic [7:0]  allOfs [6] = '{`DEMOD_CONTROL_OFS, `DEMOD_DACSELECT_OFS, `DEMOD_FALSELOCK_OFS,
                                `DEMOD_STATUS_OFS, `DEMOD_AMTC_OFS, `DEMOD_FSKDEV_OFS};
    logic [31:0] seed = 32'h8601;
    int          errors, checks, testErrs, testsRun;
    string       curTest;

    demodRegsTop dut (.*);

    initial begin
        clk = 1'b0;
        forever #(ClkNs / 2) clk = ~clk;
    end

    initial begin
        #((NumTests * 200 + RstCycles) * ClkNs);
        $display("run timed out after %0d cycles without finishing", NumTests * 200 + RstCycles);
        $display("TB FAILED");
        $finish;
    end

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int regIndex(input logic [7:0] ofs);
        for (int k = 0; k < 4; k++)
            if (ofs == ctlOfs[k])
                return k;
        return -1;
    endfunction

    function automatic logic [31:0] expectedRead(input int c, input logic [7:0] ofs);
        int idx;
        idx = regIndex(ofs);
        if (c >= NumChan)
            return '0;
        if (idx >= 0)
            return model[c][idx];
        if (ofs == `DEMOD_STATUS_OFS)
            return {23'b0, lostModel[c], 4'b0, auBitsyncLock[c], highFreqOffset[c],
                    bitsyncLock[c], demodLock[c]};
        if (ofs == `DEMOD_FSKDEV_OFS)
            return {negDeviation[c*16 +: 16], posDeviation[c*16 +: 16]};
        return '0;
    endfunction

    task automatic modelWrite(input int c, input logic [7:0] ofs, input logic [31:0] d,
                              input logic [3:0] be);
        logic [31:0] m;
        int          idx;
        idx = regIndex(ofs);
        for (int b = 0; b < 4; b++)
            m[8*b +: 8] = {8{be[b]}};
        if (c < NumChan && idx >= 0)
            model[c][idx] = ((model[c][idx] & ~m) | (d & m)) & fieldMask[idx];
        else if (c < NumChan && ofs == `DEMOD_STATUS_OFS && be[1] && d[8])
            lostModel[c] = 1'b0;
    endtask

    task automatic noteError(input string msg);
        $display("%s", msg);
        errors++;
        testErrs++;
    endtask

    task automatic checkWord(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp)
            noteError($sformatf("mismatch in %s, %s: expected %h, actual %h",
                                curTest, what, exp, act));
    endtask

    task automatic checkMode(input string what, input demodModeT exp, input demodModeT act);
        checks++;
        if (act !== exp)
            noteError($sformatf("mismatch in %s, %s: expected %0d, actual %0d",
                                curTest, what, exp, act));
    endtask

    task automatic checkBitsync(input string what, input bitsyncModeT exp,
                                input bitsyncModeT act);
        checks++;
        if (act !== exp)
            noteError($sformatf("mismatch in %s, %s: expected %0d, actual %0d",
                                curTest, what, exp, act));
    endtask

    // ***********************************************************
    // Bus access
    // ***********************************************************

    task automatic setReq(input logic w, input logic r, input int c, input logic [7:0] ofs,
                          input logic [31:0] d, input logic [3:0] be);
        cs     = w || r;
        wr     = w;
        rd     = r;
        addr   = {c[3:0], ofs};
        byteEn = be;
        dataIn = d;
    endtask

    task automatic busWrite(input int c, input logic [7:0] ofs, input logic [31:0] d,
                            input logic [3:0] be);
        @(negedge clk);
        setReq(1'b1, 1'b0, c, ofs, d, be);
        modelWrite(c, ofs, d, be);
        @(negedge clk);
        setReq(1'b0, 1'b0, 0, 8'h00, '0, '0);
    endtask

    task automatic busRead(input int c, input logic [7:0] ofs, output logic [31:0] d);
        int waited;
        waited = 0;
        @(negedge clk);
        setReq(1'b0, 1'b1, c, ofs, '0, '0);
        @(negedge clk);
        setReq(1'b0, 1'b0, 0, 8'h00, '0, '0);
        while (!rdValid && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        d = rdValid ? dataOut : 'x;
        if (!rdValid)
            noteError($sformatf("error in %s: read of channel %0d offset %h never returned",
                                curTest, c, ofs));
    endtask

    task automatic readCheck(input int c, input logic [7:0] ofs);
        logic [31:0] d;
        busRead(c, ofs, d);
        checkWord($sformatf("ch%0d offset %h", c, ofs), expectedRead(c, ofs), d);
    endtask

    task automatic checkOutputs(input int c);
        checkMode($sformatf("ch%0d demodMode", c), demodModeT'(model[c][0][4:0]),
                  demodModeT'(demodMode[c*5 +: 5]));
        checkWord("enableDespreader", 32'(model[c][0][15]), 32'(enableDespreader[c]));
        checkBitsync($sformatf("ch%0d bitsyncMode", c), bitsyncModeT'(model[c][0][17:16]),
                     bitsyncModeT'(bitsyncMode[c*2 +: 2]));
        checkWord("dac selects", model[c][1], {12'b0, dac2Select[c*4 +: 4], 4'b0,
                  dac1Select[c*4 +: 4], 4'b0, dac0Select[c*4 +: 4]});
        checkWord("false lock", model[c][2],
                  {falseLockThreshold[c*16 +: 16], falseLockAlpha[c*16 +: 16]});
        checkWord("amTC", model[c][3], 32'(amTC[c*5 +: 5]));
    endtask

    task automatic startTest(input string name);
        curTest  = name;
        testErrs = 0;
        testsRun++;
    endtask

    // ***********************************************************
    // Tests
    // ***********************************************************

    task automatic testResetState();
        startTest("reset state");
        for (int c = 0; c < NumChan; c++) begin
            checkOutputs(c);
            for (int k = 0; k < 6; k++)
                readCheck(c, allOfs[k]);
        end
    endtask

    task automatic testFullWord();
        startTest("full-word write");
        for (int c = 0; c < NumChan; c++) begin
            for (int k = 0; k < 4; k++)
                busWrite(c, ctlOfs[k], nextRand(), 4'hF);
            @(negedge clk);
            for (int cc = 0; cc < NumChan; cc++)
                checkOutputs(cc);
        end
        for (int c = 0; c < NumChan; c++)
            for (int k = 0; k < 4; k++)
                readCheck(c, ctlOfs[k]);
    endtask

    task automatic testByteEnables();
        logic [31:0] r;
        logic [7:0]  ofs;
        startTest("byte enables");
        for (int i = 0; i < 12; i++) begin
            r   = nextRand();
            ofs = r[0] ? `DEMOD_FALSELOCK_OFS : `DEMOD_CONTROL_OFS;
            busWrite(r[5:4], ofs, nextRand(), r[11:8]);
            @(negedge clk);
            checkOutputs(r[5:4]);
            readCheck(r[5:4], ofs);
        end
    endtask

    task automatic testStatus();
        logic [31:0] r;
        startTest("status and deviation");
        for (int i = 0; i < 4; i++) begin
            r = nextRand();
            @(negedge clk);
            bitsyncLock    = r[3:0];
            highFreqOffset = r[7:4];
            auBitsyncLock  = r[11:8];
            posDeviation   = {nextRand(), nextRand()};
            negDeviation   = {nextRand(), nextRand()};
            for (int c = 0; c < NumChan; c++) begin
                readCheck(c, `DEMOD_STATUS_OFS);
                readCheck(c, `DEMOD_FSKDEV_OFS);
            end
        end
        // Lock drops for one cycle on channel 1.
        @(negedge clk);
        demodLock[1] = 1'b0;
        @(negedge clk);
        demodLock[1] = 1'b1;
        lostModel[1] = 1'b1;
        readCheck(1, `DEMOD_STATUS_OFS);
        readCheck(0, `DEMOD_STATUS_OFS);
        busWrite(1, `DEMOD_STATUS_OFS, 32'h100, 4'b1101);
        readCheck(1, `DEMOD_STATUS_OFS);
        busWrite(1, `DEMOD_STATUS_OFS, 32'h100, 4'b0010);
        readCheck(1, `DEMOD_STATUS_OFS);
    endtask

    task automatic testPipelined();
        logic [31:0] expQ [$];
        logic [31:0] gotQ [$];
        logic [31:0] d;
        int          chanList [10] = '{2, 2, 2, 3, 2, 3, 2, 4, 0, 3};
        logic [7:0]  ofsList [10] = '{8'h00, 8'h00, 8'h04, 8'h08, 8'h04, 8'h08, 8'h10,
                                      8'h00, 8'h18, 8'h0C};
        logic [9:0]  isWrite = 10'b00_0000_1101;
        startTest("pipelined access");
        for (int i = 0; i < 14; i++) begin
            @(negedge clk);
            if (rdValid)
                gotQ.push_back(dataOut);
            d = nextRand();
            if (i < 10 && isWrite[i]) begin
                setReq(1'b1, 1'b0, chanList[i], ofsList[i], d, 4'hF);
                modelWrite(chanList[i], ofsList[i], d, 4'hF);
            end else if (i < 10) begin
                setReq(1'b0, 1'b1, chanList[i], ofsList[i], '0, '0);
                expQ.push_back(expectedRead(chanList[i], ofsList[i]));
            end else
                setReq(1'b0, 1'b0, 0, 8'h00, '0, '0);
        end
        if (gotQ.size() != expQ.size())
            noteError($sformatf("error in %s: %0d reads issued but %0d rdValid pulses seen",
                                curTest, expQ.size(), gotQ.size()));
        else
            for (int k = 0; k < expQ.size(); k++)
                checkWord($sformatf("read %0d in issue order", k), expQ[k], gotQ[k]);
    endtask

    initial begin
        rstN = 1'b0;
        setReq(1'b0, 1'b0, 0, 8'h00, '0, '0);
        demodLock      = '1;
        bitsyncLock    = 4'b0101;
        highFreqOffset = 4'b0011;
        auBitsyncLock  = 4'b1000;
        posDeviation   = {nextRand(), nextRand()};
        negDeviation   = {nextRand(), nextRand()};
        for (int c = 0; c < NumChan; c++) begin
            lostModel[c] = 1'b0;
            for (int k = 0; k < 4; k++)
                model[c][k] = '0;
        end
        repeat (RstCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        testResetState();
        $display("%s: %0d errors", curTest, testErrs);
        testFullWord();
        $display("%s: %0d errors", curTest, testErrs);
        testByteEnables();
        $display("%s: %0d errors", curTest, testErrs);
        testStatus();
        $display("%s: %0d errors", curTest, testErrs);
        testPipelined();
        $display("%s: %0d errors", curTest, testErrs);
        $display("tests %0d, checks %0d, errors %0d", testsRun, checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/demodRegsTop.sv
`default_nettype none

`include "demodMap_defs.svh"

module demodRegsTop (
    input  logic                                   clk,
    input  logic                                   rstN,
    input  logic                                   cs,
    input  logic                                   wr,
    input  logic                                   rd,
    input  logic [`DEMOD_ADDR_W-1:0]               addr,
    input  logic [`DEMOD_BE_W-1:0]                 byteEn,
    input  logic [`DEMOD_DATA_W-1:0]               dataIn,
    output logic [`DEMOD_DATA_W-1:0]               dataOut,
    output logic                                   rdValid,
    input  logic [`DEMOD_NUM_CHAN-1:0]             demodLock,
    input  logic [`DEMOD_NUM_CHAN-1:0]             bitsyncLock,
    input  logic [`DEMOD_NUM_CHAN-1:0]             highFreqOffset,
    input  logic [`DEMOD_NUM_CHAN-1:0]             auBitsyncLock,
    input  logic [`DEMOD_NUM_CHAN*`DEMOD_DEV_W-1:0] posDeviation,
    input  logic [`DEMOD_NUM_CHAN*`DEMOD_DEV_W-1:0] negDeviation,
    output logic [`DEMOD_NUM_CHAN*5-1:0]           demodMode,
    output logic [`DEMOD_NUM_CHAN-1:0]             enableDespreader,
    output logic [`DEMOD_NUM_CHAN*2-1:0]           bitsyncMode,
    output logic [`DEMOD_NUM_CHAN*4-1:0]           dac0Select,
    output logic [`DEMOD_NUM_CHAN*4-1:0]           dac1Select,
    output logic [`DEMOD_NUM_CHAN*4-1:0]           dac2Select,
    output logic [`DEMOD_NUM_CHAN*16-1:0]          falseLockAlpha,
    output logic [`DEMOD_NUM_CHAN*16-1:0]          falseLockThreshold,
    output logic [`DEMOD_NUM_CHAN*5-1:0]           amTC
);

    import demodPkg::*;

    logic [`DEMOD_NUM_CHAN-1:0]              chanSel;
    regSelT                                  regSel;
    logic                                    wrEn;
    logic                                    rdEn;
    logic [`DEMOD_BE_W-1:0]                  wrByteEn;
    logic [`DEMOD_DATA_W-1:0]                wrData;
    logic [`DEMOD_NUM_CHAN*`DEMOD_DATA_W-1:0] bankRdData;

    busDecoder uBusDecoder (
        .clk      (clk),
        .rstN     (rstN),
        .cs       (cs),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .byteEn   (byteEn),
        .dataIn   (dataIn),
        .chanSel  (chanSel),
        .regSel   (regSel),
        .wrEn     (wrEn),
        .rdEn     (rdEn),
        .wrByteEn (wrByteEn),
        .wrData   (wrData)
    );

    // One register bank per channel.
    for (genvar c = 0; c < `DEMOD_NUM_CHAN; c++) begin : gChan
        demodRegs uDemodRegs (
            .clk                (clk),
            .rstN               (rstN),
            .sel                (chanSel[c]),
            .wrEn               (wrEn),
            .regSel             (regSel),
            .wrByteEn           (wrByteEn),
            .wrData             (wrData),
            .demodLock          (demodLock[c]),
            .bitsyncLock        (bitsyncLock[c]),
            .highFreqOffset     (highFreqOffset[c]),
            .auBitsyncLock      (auBitsyncLock[c]),
            .posDeviation       (posDeviation[c*`DEMOD_DEV_W +: `DEMOD_DEV_W]),
            .negDeviation       (negDeviation[c*`DEMOD_DEV_W +: `DEMOD_DEV_W]),
            .demodMode          (demodMode[c*5 +: 5]),
            .enableDespreader   (enableDespreader[c]),
            .bitsyncMode        (bitsyncMode[c*2 +: 2]),
            .dac0Select         (dac0Select[c*4 +: 4]),
            .dac1Select         (dac1Select[c*4 +: 4]),
            .dac2Select         (dac2Select[c*4 +: 4]),
            .falseLockAlpha     (falseLockAlpha[c*16 +: 16]),
            .falseLockThreshold (falseLockThreshold[c*16 +: 16]),
            .amTC               (amTC[c*5 +: 5]),
            .rdData             (bankRdData[c*`DEMOD_DATA_W +: `DEMOD_DATA_W])
        );
    end

    readCollector uReadCollector (
        .clk        (clk),
        .rstN       (rstN),
        .rdEn       (rdEn),
        .chanSel    (chanSel),
        .bankRdData (bankRdData),
        .dataOut    (dataOut),
        .rdValid    (rdValid)
    );

endmodule

`default_nettype wire

//--- rtl/readCollector.sv
`default_nettype none

`include "demodMap_defs.svh"

module readCollector (
    input  logic                                    clk,
    input  logic                                    rstN,
    input  logic                                    rdEn,
    input  logic [`DEMOD_NUM_CHAN-1:0]              chanSel,
    input  logic [`DEMOD_NUM_CHAN*`DEMOD_DATA_W-1:0] bankRdData,
    output logic [`DEMOD_DATA_W-1:0]                dataOut,
    output logic                                    rdValid
);

    logic [`DEMOD_DATA_W-1:0] rdWord;

    // AND-OR select.
    // No channel selected gives zero.
    always_comb begin
        rdWord = '0;
        for (int i = 0; i < `DEMOD_NUM_CHAN; i++) begin
            rdWord = rdWord
                   | (bankRdData[i*`DEMOD_DATA_W +: `DEMOD_DATA_W]
                   & {`DEMOD_DATA_W{chanSel[i]}});
        end
    end

    // dataOut holds between reads.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dataOut <= '0;
            rdValid <= 1'b0;
        end else begin
            rdValid <= rdEn;
            if (rdEn)
                dataOut <= rdWord;
        end
    end

endmodule

`default_nettype wire

//--- rtl/demodRegs.sv
`default_nettype none

`include "demodMap_defs.svh"

module demodRegs (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     sel,
    input  logic                     wrEn,
    input  demodPkg::regSelT         regSel,
    input  logic [`DEMOD_BE_W-1:0]   wrByteEn,
    input  logic [`DEMOD_DATA_W-1:0] wrData,
    input  logic                     demodLock,
    input  logic                     bitsyncLock,
    input  logic                     highFreqOffset,
    input  logic                     auBitsyncLock,
    input  logic [`DEMOD_DEV_W-1:0]  posDeviation,
    input  logic [`DEMOD_DEV_W-1:0]  negDeviation,
    output demodPkg::demodModeT      demodMode,
    output logic                     enableDespreader,
    output demodPkg::bitsyncModeT    bitsyncMode,
    output logic [3:0]               dac0Select,
    output logic [3:0]               dac1Select,
    output logic [3:0]               dac2Select,
    output logic [15:0]              falseLockAlpha,
    output logic [15:0]              falseLockThreshold,
    output logic [4:0]               amTC,
    output logic [`DEMOD_DATA_W-1:0] rdData
);

    import demodPkg::*;

    logic        wrCtrl;
    logic        wrDac;
    logic        wrFalseLock;
    logic        wrAmTc;
    logic        clrLost;
    logic        demodLockQ;
    logic        lockFall;
    logic        lostLock;
    logic [31:0] falseLockWord;

    assign wrCtrl      = sel && wrEn && (regSel == regControl);
    assign wrDac       = sel && wrEn && (regSel == regDacSelect);
    assign wrFalseLock = sel && wrEn && (regSel == regFalseLock);
    assign wrAmTc      = sel && wrEn && (regSel == regAmTc);

    // Write 1 to bit 8 clears the lost-lock flag.
    assign clrLost = sel && wrEn && (regSel == regStatus) && wrByteEn[1] && wrData[8];

    assign falseLockWord = {falseLockThreshold, falseLockAlpha};

    // ***********************************************************
    // Control fields
    // ***********************************************************

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            demodMode          <= modeAm;
            enableDespreader   <= 1'b0;
            bitsyncMode        <= bsNrz;
            dac0Select         <= '0;
            dac1Select         <= '0;
            dac2Select         <= '0;
            falseLockAlpha     <= '0;
            falseLockThreshold <= '0;
            amTC               <= '0;
        end else begin
            if (wrCtrl) begin
                if (wrByteEn[0])
                    demodMode <= demodModeT'(wrData[4:0]);
                if (wrByteEn[1])
                    enableDespreader <= wrData[15];
                if (wrByteEn[2])
                    bitsyncMode <= bitsyncModeT'(wrData[17:16]);
            end
            if (wrDac) begin
                if (wrByteEn[0])
                    dac0Select <= wrData[3:0];
                if (wrByteEn[1])
                    dac1Select <= wrData[11:8];
                if (wrByteEn[2])
                    dac2Select <= wrData[19:16];
            end
            if (wrFalseLock) begin
                if (wrByteEn[0])
                    falseLockAlpha[7:0] <= wrData[7:0];
                if (wrByteEn[1])
                    falseLockAlpha[15:8] <= wrData[15:8];
                if (wrByteEn[2])
                    falseLockThreshold[7:0] <= wrData[23:16];
                if (wrByteEn[3])
                    falseLockThreshold[15:8] <= wrData[31:24];
            end
            if (wrAmTc && wrByteEn[0])
                amTC <= wrData[4:0];
        end
    end

    // ***********************************************************
    // Sticky lost-lock flag
    // ***********************************************************

    assign lockFall = demodLockQ && !demodLock;

    // A fall on the clearing edge keeps the flag set.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            demodLockQ <= 1'b0;
            lostLock   <= 1'b0;
        end else begin
            demodLockQ <= demodLock;
            if (lockFall)
                lostLock <= 1'b1;
            else if (clrLost)
                lostLock <= 1'b0;
        end
    end

    // Read-back.
    always_comb begin
        case (regSel)
            regControl:   rdData = {14'b0, bitsyncMode, enableDespreader, 10'b0, demodMode};
            regDacSelect: rdData = {12'b0, dac2Select, 4'b0, dac1Select, 4'b0, dac0Select};
            regFalseLock: rdData = falseLockWord;
            regStatus:    rdData = {23'b0, lostLock, 4'b0,
                                    auBitsyncLock, highFreqOffset, bitsyncLock, demodLock};
            regAmTc:      rdData = {27'b0, amTC};
            regFskDev:    rdData = {negDeviation, posDeviation};
            default:      rdData = '0;
        endcase
    end

    for (genvar b = 0; b < 4; b++) begin : gFalseLockByteChk
        falseLockByteHeld: assert property (@(posedge clk) disable iff (!rstN)
            wrFalseLock && !wrByteEn[b] |=> $stable(falseLockWord[8*b +: 8]));
    end

    ctrlModeHeld: assert property (@(posedge clk) disable iff (!rstN)
        wrCtrl && !wrByteEn[0] |=> $stable(demodMode));

endmodule

`default_nettype wire

//--- rtl/busDecoder.sv
`default_nettype none

`include "demodMap_defs.svh"

module busDecoder (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       cs,
    input  logic                       wr,
    input  logic                       rd,
    input  logic [`DEMOD_ADDR_W-1:0]   addr,
    input  logic [`DEMOD_BE_W-1:0]     byteEn,
    input  logic [`DEMOD_DATA_W-1:0]   dataIn,
    output logic [`DEMOD_NUM_CHAN-1:0] chanSel,
    output demodPkg::regSelT           regSel,
    output logic                       wrEn,
    output logic                       rdEn,
    output logic [`DEMOD_BE_W-1:0]     wrByteEn,
    output logic [`DEMOD_DATA_W-1:0]   wrData
);

    import demodPkg::*;

    localparam int ChanW = `DEMOD_CHAN_MSB - `DEMOD_CHAN_LSB + 1;

    logic                       wrReq;
    logic                       rdReq;
    logic [`DEMOD_NUM_CHAN-1:0] chanSelNext;
    regSelT                     regSelNext;

    // Exactly one strobe makes a request.
    assign wrReq = cs && wr && !rd;
    assign rdReq = cs && rd && !wr;

    // One-hot channel select is zero out of range.
    always_comb begin
        for (int i = 0; i < `DEMOD_NUM_CHAN; i++) begin
            chanSelNext[i] = (addr[`DEMOD_CHAN_MSB:`DEMOD_CHAN_LSB] == ChanW'(i));
        end
    end

    always_comb begin
        case (addr[`DEMOD_CHAN_LSB-1:0])
            `DEMOD_CONTROL_OFS:   regSelNext = regControl;
            `DEMOD_DACSELECT_OFS: regSelNext = regDacSelect;
            `DEMOD_FALSELOCK_OFS: regSelNext = regFalseLock;
            `DEMOD_STATUS_OFS:    regSelNext = regStatus;
            `DEMOD_AMTC_OFS:      regSelNext = regAmTc;
            `DEMOD_FSKDEV_OFS:    regSelNext = regFskDev;
            default:              regSelNext = regNone;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrEn    <= 1'b0;
            rdEn    <= 1'b0;
            chanSel <= '0;
            regSel  <= regNone;
        end else begin
            wrEn <= wrReq;
            rdEn <= rdReq;
            if (wrReq || rdReq) begin
                chanSel <= chanSelNext;
                regSel  <= regSelNext;
            end
        end
    end

    // Write payload.
    always_ff @(posedge clk) begin
        if (wrReq) begin
            wrByteEn <= byteEn;
            wrData   <= dataIn;
        end
    end

    chanSelOneHot: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0(chanSel));

endmodule

`default_nettype wire

//--- rtl/demodPkg.sv
`default_nettype none

`include "demodMap_defs.svh"

package demodPkg;

    // Register named by the word offset.
    typedef enum logic [2:0] {
        regControl   = 3'd0,
        regDacSelect = 3'd1,
        regFalseLock = 3'd2,
        regStatus    = 3'd3,
        regAmTc      = 3'd4,
        regFskDev    = 3'd5,
        regNone      = 3'd7
    } regSelT;

    // Demodulator modes.
    // Other codes are stored as written.
    typedef enum logic [4:0] {
        modeAm    = 5'd0,
        modeFm    = 5'd1,
        modePm    = 5'd2,
        modeFsk   = 5'd3,
        modeBpsk  = 5'd4,
        modeQpsk  = 5'd5,
        modeOqpsk = 5'd6,
        modeAqpsk = 5'd7
    } demodModeT;

    // Bit synchronizer line codes.
    typedef enum logic [1:0] {
        bsNrz     = 2'd0,
        bsBiphase = 2'd1,
        bsMiller  = 2'd2,
        bsRz      = 2'd3
    } bitsyncModeT;

endpackage

`default_nettype wire

//--- rtl/demodMap_defs.svh
`ifndef DEMOD_MAP_DEFS_SVH
`define DEMOD_MAP_DEFS_SVH

// ***********************************************************
// Host bus
// ***********************************************************

`define DEMOD_ADDR_W 12
`define DEMOD_DATA_W 32
`define DEMOD_BE_W (`DEMOD_DATA_W / 8)

// ***********************************************************
// Channels
// ***********************************************************

// Channel index sits in addr[11:8], so at most 16.
`define DEMOD_NUM_CHAN 4
`define DEMOD_CHAN_MSB 11
`define DEMOD_CHAN_LSB 8

// Width of the deviation readings.
`define DEMOD_DEV_W 16

// ***********************************************************
// Register word offsets within a 256-byte channel window
// ***********************************************************

`define DEMOD_CONTROL_OFS   8'h00
`define DEMOD_DACSELECT_OFS 8'h04
`define DEMOD_FALSELOCK_OFS 8'h08
`define DEMOD_STATUS_OFS    8'h0C
`define DEMOD_AMTC_OFS      8'h10
`define DEMOD_FSKDEV_OFS    8'h14

`endif
